/* include/id_settings.svh */
// decode stage widths, machine CSR numbers and trap constants
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// datapath widths
`define ID_WORD_WD       64
`define ID_INST_WD       32
`define ID_GPR_ADDR_WD   5
`define ID_CSR_ADDR_WD   12

// machine mode CSRs
`define ID_CSR_MSTATUS   12'h300
`define ID_CSR_MTVEC     12'h305
`define ID_CSR_MEPC      12'h341
`define ID_CSR_MCAUSE    12'h342

`define ID_CAUSE_ECALL_M 11       // environment call from M-mode

// ebreak passes its code in a0
`define ID_EBREAK_GPR    5'd10

`endif

/* verilog/id_pkg.sv */
// decode stage types, operation encodings and stage buses
`include "id_settings.svh"

package id_pkg;

  typedef logic [`ID_WORD_WD-1:0]     word_t;
  typedef logic [`ID_INST_WD-1:0]     inst_t;
  typedef logic [`ID_GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [`ID_CSR_ADDR_WD-1:0] csr_addr_t;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_COPY
  } alu_op_e;

  // same encoding as load/store funct3
  typedef enum logic [2:0] {
    MEM_B = 3'd0, MEM_H = 3'd1, MEM_W = 3'd2, MEM_D = 3'd3,
    MEM_BU = 3'd4, MEM_HU = 3'd5, MEM_WU = 3'd6
  } mem_op_e;

  typedef enum logic [2:0] {
    CSR_NONE = 3'd0, CSR_WRITE = 3'd1, CSR_SET = 3'd2, CSR_CLEAR = 3'd3
  } csr_op_e;

  // branches keep their funct3, jumps fill the gaps
  typedef enum logic [2:0] {
    BR_BEQ = 3'd0, BR_BNE = 3'd1, BR_JAL = 3'd2, BR_JALR = 3'd3,
    BR_BLT = 3'd4, BR_BGE = 3'd5, BR_BLTU = 3'd6, BR_BGEU = 3'd7
  } br_func_e;

  typedef struct packed {
    inst_t inst;
    word_t pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } br_bus_t;

  typedef struct packed {
    logic      gpr_wen;
    gpr_addr_t gpr_waddr;
    word_t     gpr_wdata;
    logic      csr_wen;
    csr_addr_t csr_waddr;
    word_t     csr_wdata;
  } ws_to_rf_t;

  typedef struct packed {
    logic     bren;
    br_func_e brfunc;
    logic     alu_src1_sel;   // 0 rs1, 1 pc
    logic [1:0] alu_src2_sel; // 0 rs2, 1 imm, 2 constant 4
    logic     alu_word_cut;
    alu_op_e  alu_op;
    logic     gpr_wen;
    logic     csr_ren;
    logic     csr_wen;
    logic     mem_ren;
    logic     mem_wen;
    mem_op_e  mem_op;
    logic     csr_inst;       // rd gets the old csr value
    csr_op_e  csr_op;
    logic     ecall;
    logic     mret;
    logic     ebreak;
    logic     invalid;
  } dec_ctrl_t;

  typedef struct packed {
    word_t      rs1data;
    word_t      rs2data;
    word_t      csrrdata;
    word_t      imm;
    word_t      pc;
    logic       alu_src1_sel;
    logic [1:0] alu_src2_sel;
    logic       alu_word_cut;
    alu_op_e    alu_op;
    gpr_addr_t  rd;
    csr_addr_t  csr;
    logic       gpr_wen;
    logic       csr_wen;
    logic       mem_ren;
    logic       mem_wen;
    mem_op_e    mem_op;
    logic       csr_inst;
    csr_op_e    csr_op;
    logic       ebreak;
    logic       invalid;
  } ds_to_es_t;

endpackage

/* verilog/inst_decoder.sv */
// RV64I decoder with CSR access and machine system instructions
`include "id_settings.svh"

module inst_decoder
  import id_pkg::*;
(
  input  inst_t     i_inst,
  output gpr_addr_t o_rs1,
  output gpr_addr_t o_rs2,
  output gpr_addr_t o_rd,
  output word_t     o_imm,
  output csr_addr_t o_csr,
  output dec_ctrl_t o_ctrl
);

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       shamt_bad;
  logic       use_rs1;
  logic       use_rs2;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t      imm;
  csr_addr_t  csr;
  dec_ctrl_t  ctrl;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // shamt[5] is reserved in the word forms
  assign shamt_bad = i_inst[31] || (|i_inst[29:26]) || (funct3 == 3'd1 && i_inst[30])
                     || (opcode == OP_IMM32 && i_inst[25]);

  function automatic alu_op_e alu_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl    = '0;
    imm     = '0;
    csr     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OP_LUI, OP_AUIPC: begin
        imm               = imm_u;
        ctrl.alu_src1_sel = (opcode == OP_AUIPC);
        ctrl.alu_src2_sel = 2'd1;
        ctrl.alu_op       = (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
        ctrl.gpr_wen      = 1'b1;
      end
      OP_JAL, OP_JALR: begin
        imm               = (opcode == OP_JAL) ? imm_j : imm_i;
        use_rs1           = (opcode == OP_JALR);
        ctrl.bren         = 1'b1;
        ctrl.brfunc       = (opcode == OP_JAL) ? BR_JAL : BR_JALR;
        ctrl.alu_src1_sel = 1'b1;
        ctrl.alu_src2_sel = 2'd2;   // link is pc + 4
        ctrl.gpr_wen      = 1'b1;
        ctrl.invalid      = (opcode == OP_JALR) && (funct3 != 3'd0);
      end
      OP_BRANCH: begin
        imm          = imm_b;
        use_rs1      = 1'b1;
        use_rs2      = 1'b1;
        ctrl.bren    = 1'b1;
        ctrl.brfunc  = br_func_e'(funct3);
        ctrl.invalid = (funct3[2:1] == 2'b01);
      end
      OP_LOAD, OP_STORE: begin
        imm               = (opcode == OP_LOAD) ? imm_i : imm_s;
        use_rs1           = 1'b1;
        use_rs2           = (opcode == OP_STORE);
        ctrl.alu_src2_sel = 2'd1;
        ctrl.mem_ren      = (opcode == OP_LOAD);
        ctrl.mem_wen      = (opcode == OP_STORE);
        ctrl.gpr_wen      = (opcode == OP_LOAD);
        ctrl.mem_op       = mem_op_e'(funct3);
        ctrl.invalid      = (opcode == OP_LOAD) ? (funct3 == 3'd7) : funct3[2];
      end
      OP_IMM, OP_IMM32: begin
        imm               = imm_i;
        use_rs1           = 1'b1;
        ctrl.alu_src2_sel = 2'd1;
        ctrl.alu_word_cut = (opcode == OP_IMM32);
        ctrl.alu_op       = alu_f3(funct3, funct3 == 3'd5 && i_inst[30]);
        ctrl.gpr_wen      = 1'b1;
        ctrl.invalid      = (funct3[1:0] == 2'b01 && shamt_bad)
                            || (opcode == OP_IMM32 && !(funct3 inside {3'd0, 3'd1, 3'd5}));
      end
      OP_REG, OP_REG32: begin
        use_rs1           = 1'b1;
        use_rs2           = 1'b1;
        ctrl.alu_word_cut = (opcode == OP_REG32);
        ctrl.alu_op       = alu_f3(funct3, funct7[5]);
        ctrl.gpr_wen      = 1'b1;
        ctrl.invalid      = ((funct7 & 7'b1011111) != '0)
                            || (funct7[5] && funct3 != 3'd0 && funct3 != 3'd5)
                            || (opcode == OP_REG32 && !(funct3 inside {3'd0, 3'd1, 3'd5}));
      end
      OP_FENCE: ;   // in-order, nothing to order
      OP_SYSTEM: begin
        if (funct3 != 3'd0) begin
          use_rs1       = 1'b1;
          csr           = i_inst[31:20];
          ctrl.csr_inst = 1'b1;
          ctrl.csr_ren  = 1'b1;
          // csrrs/csrrc from x0 only read
          ctrl.csr_wen  = (funct3[1:0] == 2'd1) || (i_inst[19:15] != '0);
          ctrl.gpr_wen  = 1'b1;
          ctrl.alu_op   = ALU_COPY;
          ctrl.csr_op   = csr_op_e'({1'b0, funct3[1:0]});
          ctrl.invalid  = funct3[2];   // no immediate forms
        end else begin
          case (i_inst[31:7])
            25'h0: begin
              ctrl.ecall = 1'b1;
              csr        = `ID_CSR_MTVEC;
            end
            {12'h001, 13'h0}: begin
              ctrl.ebreak = 1'b1;
            end
            {12'h302, 13'h0}: begin
              ctrl.mret = 1'b1;
              csr       = `ID_CSR_MEPC;
            end
            default: ctrl.invalid = 1'b1;
          endcase
        end
      end
      default: ctrl.invalid = 1'b1;
    endcase
    if (ctrl.invalid) begin
      ctrl.gpr_wen = 1'b0;
      ctrl.csr_wen = 1'b0;
      ctrl.mem_wen = 1'b0;
      ctrl.mem_ren = 1'b0;
      ctrl.bren    = 1'b0;
    end
  end

  // unused sources read as x0 so they never raise a hazard
  assign o_rs1  = ctrl.ebreak ? `ID_EBREAK_GPR : (use_rs1 ? i_inst[19:15] : '0);
  assign o_rs2  = use_rs2 ? i_inst[24:20] : '0;
  assign o_rd   = i_inst[11:7];
  assign o_imm  = imm;
  assign o_csr  = csr;
  assign o_ctrl = ctrl;

  assert property (@(i_inst) !(o_ctrl.gpr_wen && o_ctrl.mem_wen));

endmodule

/* verilog/gpr_file.sv */
// 32 x 64 general purpose registers, two async read ports, x0 tied to zero
`include "id_settings.svh"

module gpr_file
  import id_pkg::*;
(
  input  logic      i_clk,
  input  gpr_addr_t i_raddr1,
  output word_t     o_rdata1,
  input  gpr_addr_t i_raddr2,
  output word_t     o_rdata2,
  input  logic      i_wen,
  input  gpr_addr_t i_waddr,
  input  word_t     i_wdata
);

  word_t regs [1 << `ID_GPR_ADDR_WD];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* verilog/csr_file.sv */
// machine CSRs with writeback port and ECALL trap capture
`include "id_settings.svh"

module csr_file
  import id_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  csr_addr_t i_raddr,
  output word_t     o_rdata,
  input  logic      i_wen,
  input  csr_addr_t i_waddr,
  input  word_t     i_wdata,
  input  logic      i_trap,
  input  word_t     i_epc,
  output word_t     o_mtvec,
  output word_t     o_mepc
);

  word_t mstatus;
  word_t mtvec;
  word_t mepc;
  word_t mcause;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (i_wen) begin
        case (i_waddr)
          `ID_CSR_MSTATUS: mstatus <= i_wdata;
          `ID_CSR_MTVEC:   mtvec   <= i_wdata;
          `ID_CSR_MEPC:    mepc    <= i_wdata;
          `ID_CSR_MCAUSE:  mcause  <= i_wdata;
          default: ;
        endcase
      end
      if (i_trap) begin   // wins over a writeback to the same csr
        mepc   <= i_epc;
        mcause <= word_t'(`ID_CAUSE_ECALL_M);
      end
    end
  end

  always_comb begin
    case (i_raddr)
      `ID_CSR_MSTATUS: o_rdata = mstatus;
      `ID_CSR_MTVEC:   o_rdata = mtvec;
      `ID_CSR_MEPC:    o_rdata = mepc;
      `ID_CSR_MCAUSE:  o_rdata = mcause;
      default:         o_rdata = '0;
    endcase
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

  assert property (@(posedge i_clk) disable iff (i_rst)
    i_trap |=> mcause == `ID_CAUSE_ECALL_M);

endmodule

/* verilog/branch_unit.sv */
// branch condition and redirect target for branches, jumps, ecall and mret
`include "id_settings.svh"

module branch_unit
  import id_pkg::*;
(
  input  word_t     i_rs1data,
  input  word_t     i_rs2data,
  input  word_t     i_pc,
  input  word_t     i_imm,
  input  logic      i_valid,
  input  dec_ctrl_t i_ctrl,
  input  word_t     i_mtvec,
  input  word_t     i_mepc,
  output br_bus_t   o_br_bus
);

  logic  eq;
  logic  lt;
  logic  ltu;
  logic  cond;
  logic  taken;
  word_t target;

  assign eq  = (i_rs1data == i_rs2data);
  assign lt  = ($signed(i_rs1data) < $signed(i_rs2data));
  assign ltu = (i_rs1data < i_rs2data);

  always_comb begin
    case (i_ctrl.brfunc)
      BR_BEQ:  cond = eq;
      BR_BNE:  cond = !eq;
      BR_BLT:  cond = lt;
      BR_BGE:  cond = !lt;
      BR_BLTU: cond = ltu;
      BR_BGEU: cond = !ltu;
      default: cond = 1'b1;   // jal, jalr
    endcase
  end

  always_comb begin
    if (i_ctrl.ecall) begin
      target = i_mtvec;
    end else if (i_ctrl.mret) begin
      target = i_mepc;
    end else if (i_ctrl.brfunc == BR_JALR) begin
      target = (i_rs1data + i_imm) & ~word_t'(1);
    end else begin
      target = i_pc + i_imm;
    end
  end

  assign taken    = i_valid && ((i_ctrl.bren && cond) || i_ctrl.ecall || i_ctrl.mret);
  assign o_br_bus = '{taken: taken, target: target};

endmodule

/* verilog/id_stage.sv */
// instruction decode stage with stage register, hazard stall and fetch redirect
`include "id_settings.svh"

module id_stage
  import id_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_es_allowin,
  output logic      o_ds_allowin,
  input  logic      i_fs_to_ds_valid,
  input  fs_to_ds_t i_fs_to_ds_bus,
  output logic      o_ds_to_es_valid,
  output ds_to_es_t o_ds_to_es_bus,
  output br_bus_t   o_br_bus,
  input  ws_to_rf_t i_ws_to_rf_bus,
  input  gpr_addr_t i_es_rd,
  input  gpr_addr_t i_ms_rd,
  input  gpr_addr_t i_ws_rd,
  input  csr_addr_t i_es_csr,
  input  csr_addr_t i_ms_csr,
  input  csr_addr_t i_ws_csr
);

  logic      ds_valid;
  logic      ds_ready_go;
  logic      ds_fire;
  logic      gpr_hazard;
  logic      csr_hazard;
  fs_to_ds_t ds_r;
  gpr_addr_t rs1, rs2, rd;
  word_t     imm, rs1data, rs2data, csrrdata, mtvec, mepc;
  csr_addr_t csr;
  dec_ctrl_t ctrl;

  function automatic logic gpr_hit(input gpr_addr_t dst, input gpr_addr_t a,
                                   input gpr_addr_t b);
    return (dst != '0) && (dst == a || dst == b);
  endfunction

  // rs1 already points at a0 for ebreak
  assign gpr_hazard = gpr_hit(i_es_rd, rs1, rs2) || gpr_hit(i_ms_rd, rs1, rs2)
                      || gpr_hit(i_ws_rd, rs1, rs2);
  assign csr_hazard = (csr != '0) && (csr == i_es_csr || csr == i_ms_csr || csr == i_ws_csr);

  assign ds_ready_go      = !(gpr_hazard || csr_hazard);
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign ds_fire          = o_ds_to_es_valid && i_es_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !o_br_bus.taken;   // drop wrong-path fetch
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin && !o_br_bus.taken) begin
      ds_r <= i_fs_to_ds_bus;
    end
  end

  inst_decoder u_decoder (
    .i_inst (ds_r.inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm),
    .o_csr  (csr),
    .o_ctrl (ctrl)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rs1data),
    .i_raddr2 (rs2),
    .o_rdata2 (rs2data),
    .i_wen    (i_ws_to_rf_bus.gpr_wen),
    .i_waddr  (i_ws_to_rf_bus.gpr_waddr),
    .i_wdata  (i_ws_to_rf_bus.gpr_wdata)
  );

  csr_file u_csrs (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_raddr (csr),
    .o_rdata (csrrdata),
    .i_wen   (i_ws_to_rf_bus.csr_wen),
    .i_waddr (i_ws_to_rf_bus.csr_waddr),
    .i_wdata (i_ws_to_rf_bus.csr_wdata),
    .i_trap  (ds_fire && ctrl.ecall),
    .i_epc   (ds_r.pc),
    .o_mtvec (mtvec),
    .o_mepc  (mepc)
  );

  branch_unit u_bru (
    .i_rs1data (rs1data),
    .i_rs2data (rs2data),
    .i_pc      (ds_r.pc),
    .i_imm     (imm),
    .i_valid   (o_ds_to_es_valid),
    .i_ctrl    (ctrl),
    .i_mtvec   (mtvec),
    .i_mepc    (mepc),
    .o_br_bus  (o_br_bus)
  );

  assign o_ds_to_es_bus = '{
    rs1data:      rs1data,
    rs2data:      rs2data,
    csrrdata:     csrrdata,
    imm:          imm,
    pc:           ds_r.pc,
    alu_src1_sel: ctrl.alu_src1_sel,
    alu_src2_sel: ctrl.alu_src2_sel,
    alu_word_cut: ctrl.alu_word_cut,
    alu_op:       ctrl.alu_op,
    rd:           rd,
    csr:          csr,
    gpr_wen:      ctrl.gpr_wen,
    csr_wen:      ctrl.csr_wen,
    mem_ren:      ctrl.mem_ren,
    mem_wen:      ctrl.mem_wen,
    mem_op:       ctrl.mem_op,
    csr_inst:     ctrl.csr_inst,
    csr_op:       ctrl.csr_op,
    ebreak:       ctrl.ebreak,
    invalid:      ctrl.invalid
  };

  // held output frozen while execute back-pressures
  assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid && !i_es_allowin |=> $stable(o_ds_to_es_bus));

endmodule

/* sim/tb_id_stage.sv */
// decode stage testbench acting as fetch, execute and writeback
`include "id_settings.svh"

module tb_id_stage
  import id_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_rows      = 19;
  localparam int cycle_limit = n_rows * 12 + 20;
  localparam inst_t junk_inst = 32'h00108093;   // addi x1, x1, 1 on the wrong path

  // expected flags as {gpr_wen, mem_ren, mem_wen, csr_wen, alu_word_cut, ebreak, invalid}
  localparam logic [6:0] ctl_none  = 7'b0000000;
  localparam logic [6:0] ctl_wb    = 7'b1000000;
  localparam logic [6:0] ctl_wb32  = 7'b1000100;
  localparam logic [6:0] ctl_load  = 7'b1100000;
  localparam logic [6:0] ctl_store = 7'b0010000;
  localparam logic [6:0] ctl_brk   = 7'b0000010;
  localparam logic [6:0] ctl_bad   = 7'b0000001;

  typedef struct packed {
    inst_t      inst;
    word_t      pc;
    gpr_addr_t  rd;
    word_t      imm;
    logic [4:0] alu_op;
    logic [6:0] ctl;
    logic [2:0] mem_op;
    gpr_addr_t  rs1;        // rs1data shows this register's model value
    gpr_addr_t  rs2;
    word_t      csrr;
    logic       gw_en;
    logic       gw_rand;
    gpr_addr_t  gw_addr;
    word_t      gw_data;
    logic       cw_en;
    csr_addr_t  cw_addr;
    word_t      cw_data;
    logic [1:0] hz_stage;   // 0 execute, 1 memory, 2 writeback
    gpr_addr_t  hz_rd;
    csr_addr_t  hz_csr;
    logic [3:0] hz_cycles;
    logic [3:0] bp_cycles;
    logic       taken;
    word_t      target;
  } row_t;

  logic      clk;
  logic      rst;
  logic      es_allowin;
  logic      ds_allowin;
  logic      fs_valid;
  logic      ds_valid;
  fs_to_ds_t fs_bus;
  ds_to_es_t ds_bus;
  br_bus_t   br_bus;
  ws_to_rf_t ws_bus;
  gpr_addr_t es_rd, ms_rd, ws_rd;
  csr_addr_t es_csr, ms_csr, ws_csr;

  row_t  rows [n_rows];
  string names [n_rows];
  word_t model_gpr [32];
  int    n_added = 0;
  int    row_errs = 0;
  int    passed = 0;
  int    failed = 0;
  int    cycles = 0;

  id_stage id_stage_inst (
    .i_clk            (clk),
    .i_rst            (rst),
    .i_es_allowin     (es_allowin),
    .o_ds_allowin     (ds_allowin),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds_bus   (fs_bus),
    .o_ds_to_es_valid (ds_valid),
    .o_ds_to_es_bus   (ds_bus),
    .o_br_bus         (br_bus),
    .i_ws_to_rf_bus   (ws_bus),
    .i_es_rd          (es_rd),
    .i_ms_rd          (ms_rd),
    .i_ws_rd          (ws_rd),
    .i_es_csr         (es_csr),
    .i_ms_csr         (ms_csr),
    .i_ws_csr         (ws_csr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run exceeded %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic void add_row(input string name, input inst_t inst, input word_t pc,
                                  input gpr_addr_t rd, input word_t imm, input alu_op_e alu_op,
                                  input logic [6:0] ctl, input mem_op_e mem_op,
                                  input gpr_addr_t rs1, input gpr_addr_t rs2);
    row_t r;
    r        = '0;
    r.inst   = inst;
    r.pc     = pc;
    r.rd     = rd;
    r.imm    = imm;
    r.alu_op = alu_op;
    r.ctl    = ctl;
    r.mem_op = mem_op;
    r.rs1    = rs1;
    r.rs2    = rs2;
    names[n_added] = name;
    rows[n_added]  = r;
    n_added++;
  endfunction

  function automatic void gpr_write_first(input gpr_addr_t addr, input logic rnd,
                                          input word_t data);
    rows[n_added-1].gw_en   = 1'b1;
    rows[n_added-1].gw_rand = rnd;
    rows[n_added-1].gw_addr = addr;
    rows[n_added-1].gw_data = data;
  endfunction

  function automatic void csr_write_first(input csr_addr_t addr, input word_t data);
    rows[n_added-1].cw_en   = 1'b1;
    rows[n_added-1].cw_addr = addr;
    rows[n_added-1].cw_data = data;
  endfunction

  function automatic void hold_hazard(input logic [1:0] stage, input gpr_addr_t rd,
                                      input csr_addr_t csr, input logic [3:0] n);
    rows[n_added-1].hz_stage  = stage;
    rows[n_added-1].hz_rd     = rd;
    rows[n_added-1].hz_csr    = csr;
    rows[n_added-1].hz_cycles = n;
  endfunction

  function automatic void stall_execute(input logic [3:0] n);
    rows[n_added-1].bp_cycles = n;
  endfunction

  function automatic void redirect_to(input logic taken, input word_t target);
    rows[n_added-1].taken  = taken;
    rows[n_added-1].target = target;
  endfunction

  function automatic void csr_reads(input word_t data);
    rows[n_added-1].csrr = data;
  endfunction

  function automatic void build_table();
    add_row("addi", 32'hFFB08193, 64'h100, 5'd3, 64'hFFFF_FFFF_FFFF_FFFB, ALU_ADD,
            ctl_wb, MEM_B, 5'd1, 5'd0);
    gpr_write_first(5'd1, 1'b1, '0);
    add_row("addw", 32'h0020823B, 64'h104, 5'd4, 64'h0, ALU_ADD,
            ctl_wb32, MEM_B, 5'd1, 5'd2);
    gpr_write_first(5'd2, 1'b1, '0);
    add_row("lui", 32'h123452B7, 64'h108, 5'd5, 64'h1234_5000, ALU_LUI,
            ctl_wb, MEM_B, 5'd0, 5'd0);
    add_row("auipc", 32'h80000317, 64'h10C, 5'd6, 64'hFFFF_FFFF_8000_0000, ALU_ADD,
            ctl_wb, MEM_B, 5'd0, 5'd0);
    add_row("sd", 32'hFE70BC23, 64'h110, 5'd24, 64'hFFFF_FFFF_FFFF_FFF8, ALU_ADD,
            ctl_store, MEM_D, 5'd1, 5'd7);
    gpr_write_first(5'd7, 1'b1, '0);
    add_row("ld", 32'h0103B403, 64'h114, 5'd8, 64'h10, ALU_ADD, ctl_load, MEM_D, 5'd7, 5'd0);
    add_row("unused opcode", 32'h0000007F, 64'h118, 5'd0, 64'h0, ALU_ADD,
            ctl_bad, MEM_B, 5'd0, 5'd0);
    add_row("x0 write", 32'h001004B3, 64'h11C, 5'd9, 64'h0, ALU_ADD, ctl_wb, MEM_B, 5'd0, 5'd1);
    gpr_write_first(5'd0, 1'b1, '0);
    add_row("gpr hazard", 32'h00110513, 64'h120, 5'd10, 64'h1, ALU_ADD,
            ctl_wb, MEM_B, 5'd2, 5'd0);
    hold_hazard(2'd0, 5'd2, '0, 4'd3);
    add_row("csr hazard", 32'h305025F3, 64'h124, 5'd11, 64'h0, ALU_COPY,
            ctl_wb, MEM_B, 5'd0, 5'd0);
    csr_write_first(`ID_CSR_MTVEC, 64'h8000_0100);
    hold_hazard(2'd1, '0, `ID_CSR_MTVEC, 4'd2);
    csr_reads(64'h8000_0100);
    add_row("ebreak hazard", 32'h00100073, 64'h128, 5'd0, 64'h0, ALU_ADD,
            ctl_brk, MEM_B, `ID_EBREAK_GPR, 5'd0);
    gpr_write_first(`ID_EBREAK_GPR, 1'b1, '0);
    hold_hazard(2'd2, `ID_EBREAK_GPR, '0, 4'd2);
    add_row("back-pressure", 32'h7FF08613, 64'h12C, 5'd12, 64'h7FF, ALU_ADD,
            ctl_wb, MEM_B, 5'd1, 5'd0);
    stall_execute(4'd4);
    add_row("beq equal", 32'h00108863, 64'h1000, 5'd16, 64'h10, ALU_ADD,
            ctl_none, MEM_B, 5'd1, 5'd1);
    redirect_to(1'b1, 64'h1010);
    add_row("beq unequal", 32'h00208863, 64'h1010, 5'd16, 64'h10, ALU_ADD,
            ctl_none, MEM_B, 5'd1, 5'd2);
    add_row("jalr", 32'h010280E7, 64'h2000, 5'd1, 64'h10, ALU_ADD, ctl_wb, MEM_B, 5'd5, 5'd0);
    gpr_write_first(5'd5, 1'b0, 64'h1001);
    redirect_to(1'b1, 64'h1010);   // low bit of 0x1011 cleared
    add_row("ecall", 32'h00000073, 64'h3000, 5'd0, 64'h0, ALU_ADD, ctl_none, MEM_B, 5'd0, 5'd0);
    csr_reads(64'h8000_0100);
    redirect_to(1'b1, 64'h8000_0100);
    add_row("read mepc", 32'h341026F3, 64'h8000_0100, 5'd13, 64'h0, ALU_COPY,
            ctl_wb, MEM_B, 5'd0, 5'd0);
    csr_reads(64'h3000);
    add_row("read mcause", 32'h34202773, 64'h8000_0104, 5'd14, 64'h0, ALU_COPY,
            ctl_wb, MEM_B, 5'd0, 5'd0);
    csr_reads(64'd11);   // environment call from M-mode
    add_row("mret", 32'h30200073, 64'h8000_0108, 5'd0, 64'h0, ALU_ADD,
            ctl_none, MEM_B, 5'd0, 5'd0);
    csr_reads(64'h3000);
    redirect_to(1'b1, 64'h3000);
  endfunction

  task automatic compare_field(input string what, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      row_errs++;
    end
  endtask

  task automatic require(input bit cond, input string what);
    assert (cond) else begin
      $display("error at %0t ns: %s", $time, what);
      row_errs++;
    end
  endtask

  task automatic report_row(input string name);
    if (row_errs == 0) begin
      passed++;
      $display("%s: pass", name);
    end else begin
      failed++;
      $display("%s: fail, %0d errors", name, row_errs);
    end
  endtask

  task automatic run_row(input int idx);
    row_t      r;
    word_t     data;
    ds_to_es_t snap;
    int        waited;
    r        = rows[idx];
    row_errs = 0;
    waited   = 0;
    @(posedge clk);
    #1;
    if (r.gw_en || r.cw_en) begin
      data = r.gw_rand ? {$urandom(), $urandom()} : r.gw_data;
      ws_bus.gpr_wen   = r.gw_en;
      ws_bus.gpr_waddr = r.gw_addr;
      ws_bus.gpr_wdata = data;
      ws_bus.csr_wen   = r.cw_en;
      ws_bus.csr_waddr = r.cw_addr;
      ws_bus.csr_wdata = r.cw_data;
      if (r.gw_en && r.gw_addr != '0) model_gpr[r.gw_addr] = data;   // x0 stays zero
      @(posedge clk);
      #1;
      ws_bus = '0;
    end
    case (r.hz_stage)
      2'd0: begin
        es_rd  = r.hz_rd;
        es_csr = r.hz_csr;
      end
      2'd1: begin
        ms_rd  = r.hz_rd;
        ms_csr = r.hz_csr;
      end
      default: begin
        ws_rd  = r.hz_rd;
        ws_csr = r.hz_csr;
      end
    endcase
    fs_valid   = 1'b1;
    fs_bus     = '{inst: r.inst, pc: r.pc};
    es_allowin = (r.bp_cycles == 0);
    @(negedge clk);
    require(ds_allowin, "empty stage refused an instruction");
    @(posedge clk);
    #1;
    fs_valid = r.taken;   // wrong-path fetch behind a redirect
    fs_bus   = '{inst: junk_inst, pc: r.pc + 4};
    repeat (r.hz_cycles) begin
      @(negedge clk);
      require(!ds_valid && !ds_allowin, "stage did not stall on a pending destination");
      @(posedge clk);
      #1;
    end
    {es_rd, ms_rd, ws_rd} = '0;
    {es_csr, ms_csr, ws_csr} = '0;
    @(negedge clk);
    while (!ds_valid) begin
      waited++;
      @(negedge clk);
    end
    require(waited == 0, "instruction left later than one cycle after the stall cleared");
    compare_field("rd", word_t'(ds_bus.rd), word_t'(r.rd));
    compare_field("imm", ds_bus.imm, r.imm);
    compare_field("alu_op", word_t'(ds_bus.alu_op), word_t'(r.alu_op));
    compare_field("flags", word_t'({ds_bus.gpr_wen, ds_bus.mem_ren, ds_bus.mem_wen,
                                    ds_bus.csr_wen, ds_bus.alu_word_cut, ds_bus.ebreak,
                                    ds_bus.invalid}), word_t'(r.ctl));
    compare_field("mem_op", word_t'(ds_bus.mem_op), word_t'(r.mem_op));
    compare_field("rs1data", ds_bus.rs1data, model_gpr[r.rs1]);
    compare_field("rs2data", ds_bus.rs2data, model_gpr[r.rs2]);
    compare_field("csrrdata", ds_bus.csrrdata, r.csrr);
    compare_field("pc", ds_bus.pc, r.pc);
    compare_field("taken", word_t'(br_bus.taken), word_t'(r.taken));
    if (r.taken) compare_field("target", br_bus.target, r.target);
    snap = ds_bus;
    repeat (r.bp_cycles) begin
      @(posedge clk);
      #1;
      fs_valid = 1'b1;   // next fetch waits
      @(negedge clk);
      require(ds_valid && !ds_allowin, "stage opened to fetch under back-pressure");
      assert (ds_bus === snap) else begin
        $display("MISMATCH at %0t ns: output bus changed under back-pressure", $time);
        row_errs++;
      end
    end
    if (r.bp_cycles != 0) begin
      @(posedge clk);
      #1;
      fs_valid   = r.taken;
      es_allowin = 1'b1;
    end
    @(posedge clk);   // transfer edge
    #1;
    fs_valid = 1'b0;
    @(negedge clk);
    require(!ds_valid && ds_allowin, "stage not empty after the transfer");
    report_row(names[idx]);
  endtask

  initial begin
    void'($urandom(29));
    rst        = 1'b1;
    es_allowin = 1'b1;
    fs_valid   = 1'b0;
    fs_bus     = '0;
    ws_bus     = '0;
    {es_rd, ms_rd, ws_rd} = '0;
    {es_csr, ms_csr, ws_csr} = '0;
    foreach (model_gpr[i]) model_gpr[i] = '0;
    build_table();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    require(!ds_valid && !br_bus.taken && ds_allowin, "outputs not idle after reset");
    report_row("reset");
    for (int i = 0; i < n_added; i++) begin
      run_row(i);
    end
    $display("%0d passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/gpr_file.sv
verilog/csr_file.sv
verilog/branch_unit.sv
verilog/id_stage.sv
sim/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - include
    files:
      - verilog/id_pkg.sv
      - verilog/inst_decoder.sv
      - verilog/gpr_file.sv
      - verilog/csr_file.sv
      - verilog/branch_unit.sv
      - verilog/id_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_id_stage.sv
